//--- rtl/core_pkg.sv
package core_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and constants
    ////////////////////////////////////////////////////////////
    localparam int unsigned xlen = 32;
    localparam int unsigned reg_aw = 5;
    localparam int unsigned dmem_aw = 8;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    // ADDI x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    // Major opcodes of the kept subset
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_e;

    typedef enum logic [1:0] {fwd_rf, fwd_em, fwd_wb} fwd_src_e;

    ////////////////////////////////////////////////////////////
    // Pipeline bundles
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fd_t;

    typedef struct packed {
        logic              valid;
        logic [xlen-1:0]   pc;
        logic [reg_aw-1:0] rd;
        logic [reg_aw-1:0] rs1;
        logic [reg_aw-1:0] rs2;
        logic [xlen-1:0]   rs1_val;
        logic [xlen-1:0]   rs2_val;
        logic [xlen-1:0]   imm;
        logic              use_imm;
        alu_op_e           alu_op;
        wb_sel_e           wb_sel;
        logic              mem_write;
        logic              is_load;
    } de_t;

    typedef struct packed {
        logic              valid;
        logic [xlen-1:0]   pc;
        logic [reg_aw-1:0] rd;
        logic [xlen-1:0]   result;
        logic [xlen-1:0]   store_data;
        logic              mem_write;
        wb_sel_e           wb_sel;
    } em_t;

    // rd is zero when nothing is written
    typedef struct packed {
        logic              valid;
        logic [xlen-1:0]   pc;
        logic [reg_aw-1:0] rd;
        logic [xlen-1:0]   data;
    } retire_t;

    // Operand select shared by the ALU and the branch comparator
    function automatic logic [xlen-1:0] fwd_mux(
        input fwd_src_e        sel,
        input logic [xlen-1:0] rf_val,
        input logic [xlen-1:0] em_val,
        input logic [xlen-1:0] wb_val
    );
        case (sel)
            fwd_em:  return em_val;
            fwd_wb:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      redirect,
    input  logic [core_pkg::xlen-1:0] target,
    input  logic [core_pkg::xlen-1:0] imem_data,
    output logic [core_pkg::xlen-1:0] imem_addr,
    output core_pkg::fd_t             fd
);

    logic [core_pkg::xlen-1:0] pc;

    // Memory returns the word for pc one clock later
    assign imem_addr = pc;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= core_pkg::reset_pc;
            fd <= '{valid: 1'b0, pc: core_pkg::reset_pc, instr: core_pkg::nop_instr};
        end else if (!stall) begin
            if (redirect) begin
                // Squash the wrong-path word already fetched
                pc <= target;
                fd <= '{valid: 1'b0, pc: pc, instr: core_pkg::nop_instr};
            end else begin
                pc <= pc + 32'd4;
                fd <= '{valid: 1'b1, pc: pc, instr: imem_data};
            end
        end
    end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  core_pkg::fd_t               fd,
    input  logic                        stall,
    input  core_pkg::fwd_src_e          br_fwd_a,
    input  core_pkg::fwd_src_e          br_fwd_b,
    input  core_pkg::em_t               em,
    input  core_pkg::retire_t           wb,
    output core_pkg::de_t               de,
    output logic                        redirect,
    output logic [core_pkg::xlen-1:0]   target,
    output logic [core_pkg::reg_aw-1:0] dec_rs1,
    output logic [core_pkg::reg_aw-1:0] dec_rs2,
    output logic                        dec_is_branch
);

    logic [31:0]                 instr;
    logic [core_pkg::reg_aw-1:0] rd;
    logic [core_pkg::xlen-1:0]   imm;
    logic                        use_imm;
    core_pkg::alu_op_e           alu_op;
    core_pkg::wb_sel_e           wb_sel;
    logic                        mem_write;
    logic                        is_load;
    logic                        is_jal;
    logic [core_pkg::xlen-1:0]   rf [0:31];
    logic [core_pkg::xlen-1:0]   rs1_val;
    logic [core_pkg::xlen-1:0]   rs2_val;
    logic [core_pkg::xlen-1:0]   br_a;
    logic [core_pkg::xlen-1:0]   br_b;
    logic [core_pkg::xlen-1:0]   imm_b;
    logic [core_pkg::xlen-1:0]   imm_j;

    assign instr = fd.instr;

    ////////////////////////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        dec_rs1 = instr[19:15];
        dec_rs2 = instr[24:20];
        rd = instr[11:7];
        imm = {{20{instr[31]}}, instr[31:20]};
        use_imm = 1'b1;
        mem_write = 1'b0;
        is_load = 1'b0;
        is_jal = 1'b0;
        dec_is_branch = 1'b0;
        wb_sel = core_pkg::wb_alu;
        case (instr[14:12])
            3'b000:  alu_op = core_pkg::alu_add;
            3'b111:  alu_op = core_pkg::alu_and;
            3'b110:  alu_op = core_pkg::alu_or;
            3'b100:  alu_op = core_pkg::alu_xor;
            3'b010:  alu_op = core_pkg::alu_slt;
            3'b001:  alu_op = core_pkg::alu_sll;
            default: alu_op = core_pkg::alu_srl;
        endcase
        // Unused source fields read as x0 so no false hazards
        case (core_pkg::opcode_e'(instr[6:0]))
            core_pkg::op_r: begin
                use_imm = 1'b0;
                if (instr[14:12] == 3'b000 && instr[30]) begin
                    alu_op = core_pkg::alu_sub;
                end
            end
            core_pkg::op_imm: dec_rs2 = '0;
            core_pkg::op_load: begin
                dec_rs2 = '0;
                alu_op = core_pkg::alu_add;
                is_load = 1'b1;
                wb_sel = core_pkg::wb_mem;
            end
            core_pkg::op_store: begin
                rd = '0;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                alu_op = core_pkg::alu_add;
                mem_write = 1'b1;
            end
            core_pkg::op_branch: begin
                rd = '0;
                dec_is_branch = 1'b1;
            end
            core_pkg::op_lui: begin
                dec_rs1 = '0;
                dec_rs2 = '0;
                imm = {instr[31:12], 12'b0};
                alu_op = core_pkg::alu_pass_b;
            end
            core_pkg::op_jal: begin
                dec_rs1 = '0;
                dec_rs2 = '0;
                alu_op = core_pkg::alu_pass_b;
                wb_sel = core_pkg::wb_pc4;
                is_jal = 1'b1;
            end
            default: begin
                dec_rs1 = '0;
                dec_rs2 = '0;
                rd = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Register file with write-through
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wb.rd != '0) begin
            rf[wb.rd] <= wb.data;
        end
    end

    assign rs1_val = (dec_rs1 == '0) ? '0 : (dec_rs1 == wb.rd) ? wb.data : rf[dec_rs1];
    assign rs2_val = (dec_rs2 == '0) ? '0 : (dec_rs2 == wb.rd) ? wb.data : rf[dec_rs2];

    // Branch resolution
    assign br_a = core_pkg::fwd_mux(br_fwd_a, rs1_val, em.result, wb.data);
    assign br_b = core_pkg::fwd_mux(br_fwd_b, rs2_val, em.result, wb.data);
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign target = fd.pc + (is_jal ? imm_j : imm_b);
    // funct3 bit 0 separates BNE from BEQ
    assign redirect = fd.valid &&
                      (is_jal || (dec_is_branch && ((br_a == br_b) ^ instr[12])));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            de <= '0;
        end else if (stall) begin
            de <= '0;
        end else begin
            de <= '{valid: fd.valid, pc: fd.pc, rd: rd, rs1: dec_rs1, rs2: dec_rs2,
                    rs1_val: rs1_val, rs2_val: rs2_val, imm: imm, use_imm: use_imm,
                    alu_op: alu_op, wb_sel: wb_sel, mem_write: mem_write,
                    is_load: is_load};
        end
    end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::de_t      de,
    input  core_pkg::fwd_src_e fwd_a,
    input  core_pkg::fwd_src_e fwd_b,
    input  core_pkg::em_t      em,
    input  core_pkg::retire_t  wb,
    output core_pkg::em_t      ex_out
);

    logic [core_pkg::xlen-1:0] op_a;
    logic [core_pkg::xlen-1:0] rs2_fwd;
    logic [core_pkg::xlen-1:0] op_b;
    logic [core_pkg::xlen-1:0] result;

    assign op_a    = core_pkg::fwd_mux(fwd_a, de.rs1_val, em.result, wb.data);
    assign rs2_fwd = core_pkg::fwd_mux(fwd_b, de.rs2_val, em.result, wb.data);

    // JAL link value rides through the pass-b path
    always_comb begin
        if (de.wb_sel == core_pkg::wb_pc4) begin
            op_b = de.pc + 32'd4;
        end else if (de.use_imm) begin
            op_b = de.imm;
        end else begin
            op_b = rs2_fwd;
        end
    end

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (de.alu_op)
            core_pkg::alu_sub: result = op_a - op_b;
            core_pkg::alu_and: result = op_a & op_b;
            core_pkg::alu_or:  result = op_a | op_b;
            core_pkg::alu_xor: result = op_a ^ op_b;
            core_pkg::alu_slt: result = {31'b0, $signed(op_a) < $signed(op_b)};
            core_pkg::alu_sll: result = op_a << op_b[4:0];
            core_pkg::alu_srl: result = op_a >> op_b[4:0];
            core_pkg::alu_pass_b: result = op_b;
            default: result = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ex_out <= '0;
        end else begin
            ex_out <= '{valid: de.valid, pc: de.pc, rd: de.rd, result: result,
                        store_data: rs2_fwd, mem_write: de.mem_write,
                        wb_sel: de.wb_sel};
        end
    end

endmodule

//--- rtl/mem_wb_stage.sv
`timescale 1ns/100ps

module mem_wb_stage (
    input  logic              clk,
    input  logic              rst,
    input  core_pkg::em_t     em,
    output core_pkg::retire_t retire
);

    logic [core_pkg::xlen-1:0]    dmem [0:2**core_pkg::dmem_aw-1];
    logic [core_pkg::dmem_aw-1:0] word_addr;
    logic [core_pkg::xlen-1:0]    wb_data;

    // Word index, byte offset dropped
    assign word_addr = em.result[core_pkg::dmem_aw+1:2];

    ////////////////////////////////////////////////////////////
    // Data memory
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (em.valid && em.mem_write) begin
            dmem[word_addr] <= em.store_data;
        end
    end

    // Combinational read, a following load sees the stored word
    assign wb_data = (em.wb_sel == core_pkg::wb_mem) ? dmem[word_addr] : em.result;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            retire <= '0;
        end else begin
            retire <= '{valid: em.valid, pc: em.pc, rd: em.rd, data: wb_data};
        end
    end

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
    input  logic [core_pkg::reg_aw-1:0] dec_rs1,
    input  logic [core_pkg::reg_aw-1:0] dec_rs2,
    input  logic                        dec_is_branch,
    input  core_pkg::de_t               de,
    input  core_pkg::em_t               em,
    input  core_pkg::retire_t           wb,
    output logic                        stall,
    output core_pkg::fwd_src_e          fwd_a,
    output core_pkg::fwd_src_e          fwd_b,
    output core_pkg::fwd_src_e          br_fwd_a,
    output core_pkg::fwd_src_e          br_fwd_b
);

    logic dep_ex;
    logic dep_mem_load;

    // Youngest nonzero producer wins, bubbles carry rd of zero
    function automatic core_pkg::fwd_src_e pick_src(
        input logic [core_pkg::reg_aw-1:0] rs,
        input logic [core_pkg::reg_aw-1:0] em_rd,
        input logic [core_pkg::reg_aw-1:0] wb_rd
    );
        if (rs != '0 && rs == em_rd) begin
            return core_pkg::fwd_em;
        end else if (rs != '0 && rs == wb_rd) begin
            return core_pkg::fwd_wb;
        end
        return core_pkg::fwd_rf;
    endfunction

    ////////////////////////////////////////////////////////////
    // Forwarding selects
    ////////////////////////////////////////////////////////////
    assign fwd_a    = pick_src(de.rs1, em.rd, wb.rd);
    assign fwd_b    = pick_src(de.rs2, em.rd, wb.rd);
    assign br_fwd_a = pick_src(dec_rs1, em.rd, wb.rd);
    assign br_fwd_b = pick_src(dec_rs2, em.rd, wb.rd);

    ////////////////////////////////////////////////////////////
    // Stall detection
    ////////////////////////////////////////////////////////////

    // Decode reads what execute is producing right now
    assign dep_ex = (de.rd != '0) && (de.rd == dec_rs1 || de.rd == dec_rs2);

    // Load data only exists at the end of the memory stage
    assign dep_mem_load = (em.wb_sel == core_pkg::wb_mem) && (em.rd != '0) &&
                          (em.rd == dec_rs1 || em.rd == dec_rs2);

    // Load-use costs one cycle, a branch on a load two
    assign stall = (de.is_load && dep_ex) ||
                   (dec_is_branch && (dep_ex || dep_mem_load));

endmodule

//--- rtl/riscv_core.sv
`timescale 1ns/100ps

module riscv_core (
    input  logic                         clk,
    input  logic                         rst,
    output logic [core_pkg::xlen-1:0]    imem_addr,
    input  logic [core_pkg::xlen-1:0]    imem_data,
    output core_pkg::retire_t            retire
);

    core_pkg::fd_t                fd;
    core_pkg::de_t                de;
    core_pkg::em_t                em;
    logic                         stall;
    logic                         redirect;
    logic [core_pkg::xlen-1:0]    target;
    logic [core_pkg::reg_aw-1:0]  dec_rs1;
    logic [core_pkg::reg_aw-1:0]  dec_rs2;
    logic                         dec_is_branch;
    core_pkg::fwd_src_e           fwd_a;
    core_pkg::fwd_src_e           fwd_b;
    core_pkg::fwd_src_e           br_fwd_a;
    core_pkg::fwd_src_e           br_fwd_b;

    fetch_stage i_fetch_stage (
        .clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
        .target(target), .imem_data(imem_data),
        .imem_addr(imem_addr), .fd(fd)
    );

    decode_stage i_decode_stage (
        .clk(clk), .rst(rst), .fd(fd), .stall(stall),
        .br_fwd_a(br_fwd_a), .br_fwd_b(br_fwd_b), .em(em), .wb(retire),
        .de(de), .redirect(redirect), .target(target),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_is_branch(dec_is_branch)
    );

    execute_stage i_execute_stage (
        .clk(clk), .rst(rst), .de(de), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .em(em), .wb(retire), .ex_out(em)
    );

    mem_wb_stage i_mem_wb_stage (
        .clk(clk), .rst(rst), .em(em), .retire(retire)
    );

    hazard_unit i_hazard_unit (
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_is_branch(dec_is_branch),
        .de(de), .em(em), .wb(retire), .stall(stall),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .br_fwd_a(br_fwd_a), .br_fwd_b(br_fwd_b)
    );

endmodule

//--- sim/riscv_core_assert.sv
`timescale 1ns/100ps

module riscv_core_assert (
    input logic                        clk,
    input logic                        rst,
    input logic [core_pkg::xlen-1:0]   imem_addr,
    input core_pkg::retire_t           retire,
    input logic                        stall
);

    // Nothing retires while reset is held
    no_retire_in_reset: assert property (@(posedge clk) !rst |-> !retire.valid)
        else $error("retire valid high during reset");

    // A stalled fetch keeps its address
    fetch_holds: assert property (@(posedge clk) disable iff (!rst)
        stall |=> $stable(imem_addr))
        else $error("imem_addr changed during a stall");

    // Register file writes on rd alone, so a dead slot must name x0
    bubble_writes_nothing: assert property (@(posedge clk) disable iff (!rst)
        !retire.valid |-> retire.rd == '0)
        else $error("non-retiring slot carries a destination register");

    // Worst case is a branch on a load
    stall_limit: assert property (@(posedge clk) disable iff (!rst)
        stall && $past(stall) |=> !stall)
        else $error("stall held for more than two cycles");

endmodule

bind riscv_core riscv_core_assert i_riscv_core_assert (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .retire(retire), .stall(stall)
);

//--- sim/tb_riscv_core.sv
`timescale 1ns/100ps

module tb_riscv_core;

    // Setup words for x1..x7 and 16 data words ahead of the random part
    localparam int n_init = 23;
    localparam int n_random = 200;
    localparam int n_prog = n_init + n_random + 1;
    localparam logic [31:0] loop_pc = 32'(4 * (n_prog - 1));
    localparam int timeout_cycles = 10 * n_prog;

    logic              clk;
    logic              rst;
    logic [31:0]       imem_addr;
    logic [31:0]       imem_data;
    core_pkg::retire_t retire;

    logic [31:0] prog [0:255];
    logic [31:0] model_x [0:31];
    logic [31:0] model_mem [0:15];
    logic [31:0] model_pc;
    int unsigned seed_discard;

    riscv_core i_riscv_core (
        .clk(clk),
        .rst(rst),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .retire(retire)
    );

    ////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_format(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_format(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    ////////////////////////////////////////////////////////////
    // Random program
    ////////////////////////////////////////////////////////////
    task automatic build_program();
        int i;
        int k;
        int sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        for (i = 0; i < 256; i++) begin
            prog[8'(i)] = 32'h0000_0013;
        end
        for (i = 1; i < 8; i++) begin
            prog[8'(i - 1)] = i_format(12'($urandom), 5'd0, 3'b000, 5'(i), 7'b0010011);
        end
        for (i = 0; i < 16; i++) begin
            prog[8'(i + 7)] = s_format(12'(4 * i), 5'(i % 7 + 1), 5'd0);
        end
        for (i = n_init; i < n_init + n_random; i++) begin
            rd = 5'($urandom % 8);
            rs1 = 5'($urandom % 8);
            rs2 = 5'($urandom % 8);
            f3 = 3'($urandom % 7);
            // Skip the unsigned compare slot
            if (f3 >= 3'd3) begin
                f3 = f3 + 3'd1;
            end
            f7 = (f3 == 3'b000 && $urandom % 2 == 1) ? 7'h20 : 7'h00;
            imm = (f3 == 3'b001 || f3 == 3'b101) ? {7'b0, 5'($urandom)} : 12'($urandom);
            // Forward distance, never beyond the final loop
            k = 1 + int'($urandom % 4);
            if (i + k > n_prog - 1) begin
                k = n_prog - 1 - i;
            end
            sel = int'($urandom % 10);
            case (sel)
                0, 1, 2: prog[8'(i)] = r_format(f7, rs2, rs1, f3, rd);
                3, 4:    prog[8'(i)] = i_format(imm, rs1, f3, rd, 7'b0010011);
                5:       prog[8'(i)] = {20'($urandom), rd, 7'b0110111};
                6:       prog[8'(i)] = i_format(12'(4 * ($urandom % 16)), 5'd0, 3'b010, rd,
                                                7'b0000011);
                7:       prog[8'(i)] = s_format(12'(4 * ($urandom % 16)), rs2, 5'd0);
                8:       prog[8'(i)] = b_format(13'(4 * k), rs2, rs1, {2'b00, 1'($urandom)});
                default: prog[8'(i)] = j_format(21'(4 * k), rd);
            endcase
        end
        // Jump to itself marks the end
        prog[8'(n_prog - 1)] = j_format(21'd0, 5'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_step(output logic [4:0] exp_rd, output logic [31:0] exp_data);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] next_pc;
        ins = prog[model_pc[9:2]];
        a = model_x[ins[19:15]];
        b = model_x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        next_pc = model_pc + 32'd4;
        exp_rd = ins[11:7];
        exp_data = '0;
        case (ins[6:0])
            7'b0110011: exp_data = alu_result(ins[14:12], ins[30], a, b);
            7'b0010011: exp_data = alu_result(ins[14:12], 1'b0, a, imm_i);
            7'b0110111: exp_data = {ins[31:12], 12'b0};
            7'b0000011: exp_data = model_mem[4'((a + imm_i) >> 2)];
            7'b0100011: begin
                exp_rd = '0;
                model_mem[4'((a + imm_s) >> 2)] = b;
            end
            7'b1100011: begin
                exp_rd = '0;
                // funct3 bit 0 inverts the sense for BNE
                if ((a == b) != ins[12]) begin
                    next_pc = model_pc + imm_b;
                end
            end
            default: begin
                exp_data = model_pc + 32'd4;
                next_pc = model_pc + imm_j;
            end
        endcase
        if (exp_rd != '0) begin
            model_x[exp_rd] = exp_data;
        end
        model_pc = next_pc;
    endtask

    ////////////////////////////////////////////////////////////
    // Checks and failure
    ////////////////////////////////////////////////////////////
    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %08h, expected %08h", name, got, exp);
            abort_run();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        seed_discard = $urandom(9);
        rst = 1'b0;
        build_program();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

    // Instruction memory, word appears on the falling edge
    initial begin
        imem_data = 32'h0000_0013;
        forever begin
            @(negedge clk);
            imem_data = prog[imem_addr[9:2]];
        end
    end

    // Retire monitor, one model step per retired instruction
    initial begin
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic        at_loop;
        at_loop = 1'b0;
        model_pc = 32'h0000_0000;
        for (int i = 0; i < 32; i++) begin
            model_x[5'(i)] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            model_mem[4'(i)] = '0;
        end
        while (!at_loop) begin
            @(negedge clk);
            if (rst && retire.valid) begin
                check_value("retire.pc", retire.pc, model_pc);
                at_loop = (model_pc == loop_pc);
                model_step(exp_rd, exp_data);
                check_value("retire.rd", {27'b0, retire.rd}, {27'b0, exp_rd});
                if (exp_rd != '0) begin
                    check_value("retire.data", retire.data, exp_data);
                end
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the program reached its final loop",
                 timeout_cycles);
        abort_run();
    end

endmodule

//--- list.f
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/hazard_unit.sv
rtl/riscv_core.sv
sim/riscv_core_assert.sv
sim/tb_riscv_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_riscv_core -f list.f \
    && ./obj_dir/Vtb_riscv_core 2>&1 | tee sim.log \
    || { echo "Verilator build or run error"; exit 1; }

# The log decides the result
grep -qF "*** TEST PASSED ***" sim.log \
    && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }
